// ==== design/nes_bus_pkg.sv ====
/* Shared types, register map, NTSC divisor defaults
   and state enums for the NES CPU bus core */

package nes_bus_pkg;

	typedef logic [15:0] cpu_addr_t; // CPU side address bus
	typedef logic [7:0] byte_t;

	// Linear memory behind the PRG/CHR multiplexer
	localparam int MEM_ADDR_WIDTH_DEFAULT = 22;

	// NTSC master clock divisors
	localparam int CPU_DIV_DEFAULT = 12;
	localparam int PPU_DIV_DEFAULT = 4;

	// Single register locations
	localparam cpu_addr_t SPRITE_DMA_ADDR = 16'h4014; // Page write starts OAM copy
	localparam cpu_addr_t OAM_DATA_ADDR   = 16'h2004; // PPU OAM data port
	localparam cpu_addr_t JOY1_ADDR       = 16'h4016;
	localparam cpu_addr_t JOY2_ADDR       = 16'h4017;
	localparam cpu_addr_t APU_STATUS_ADDR = 16'h4015;

	// Decode ranges, base inclusive and end exclusive
	localparam cpu_addr_t PPU_BASE = 16'h2000;
	localparam cpu_addr_t PPU_END  = 16'h4000;
	localparam cpu_addr_t APU_BASE = 16'h4000;
	localparam cpu_addr_t APU_END  = 16'h4018;
	localparam cpu_addr_t OPEN_END = 16'h4100; // Unmapped gap after the APU range

	// Sprite DMA, bit 0 set means the CPU is held
	typedef enum logic [1:0] {
		SPR_IDLE = 2'b00,
		SPR_WAIT = 2'b01, // CPU held, bus still with CPU
		SPR_RUN  = 2'b11  // DMA owns the bus
	} spr_state_t;

	typedef enum logic {
		DMC_IDLE  = 1'b0,
		DMC_FETCH = 1'b1
	} dmc_state_t;

	// Address decode result
	typedef enum logic [2:0] {
		REGION_PPU,
		REGION_JOY1,
		REGION_JOY2,
		REGION_APU,
		REGION_OPEN,
		REGION_PRG
	} bus_region_t;

endpackage

// ==== design/clock_divider.sv ====
/* Master clock divider with CPU and PPU enables,
   M2 window, cart pre-window and odd CPU cycle flag */

`timescale 1ns/100ps

module clock_divider #(
	parameter int CPU_DIV = nes_bus_pkg::CPU_DIV_DEFAULT,
	parameter int PPU_DIV = nes_bus_pkg::PPU_DIV_DEFAULT
) (
	input  logic clk,
	input  logic reset,
	output logic cpu_ce,    // One clock every CPU_DIV
	output logic ppu_ce,    // One clock every PPU_DIV
	output logic m2,        // Phi2 high window
	output logic cart_pre,  // Early cart access window
	output logic odd_cycle  // Alternates each CPU cycle
);

	localparam int CPU_W = $clog2(CPU_DIV + 1);
	localparam int PPU_W = $clog2(PPU_DIV + 1);
	localparam int M2_START = CPU_DIV / 2 - 1; // 5 on NTSC

	logic [CPU_W-1:0] div_cpu;
	logic [PPU_W-1:0] div_ppu;

	// Both counters run 1..DIV and wrap
	always_ff @(posedge clk) begin
		if (reset) begin
			div_cpu <= CPU_W'(1);
			div_ppu <= PPU_W'(1);
		end else begin
			if (cpu_ce)
				div_cpu <= CPU_W'(1);
			else
				div_cpu <= div_cpu + CPU_W'(1);
			if (ppu_ce)
				div_ppu <= PPU_W'(1);
			else
				div_ppu <= div_ppu + PPU_W'(1);
		end
	end

	// Even cycle is the active APU half
	always_ff @(posedge clk) begin
		if (reset)
			odd_cycle <= 1'b0;
		else if (cpu_ce)
			odd_cycle <= ~odd_cycle;
	end

	assign cpu_ce = (div_cpu == CPU_W'(CPU_DIV)); // Last count of the CPU period
	assign ppu_ce = (div_ppu == PPU_W'(PPU_DIV));

	// M2 rises partway through and drops with the CPU tick
	assign m2 = (div_cpu >= CPU_W'(M2_START)) && (div_cpu < CPU_W'(CPU_DIV));

	// First PPU period of each CPU cycle, gives the cart data time
	assign cart_pre = (div_cpu >= CPU_W'(1)) && (div_cpu <= CPU_W'(PPU_DIV));

endmodule

// ==== design/dma_controller.sv ====
/* Sprite DMA and DMC DMA sequencer, pauses the CPU
   and takes the bus for OAM copies and sample fetches */

`timescale 1ns/100ps

module dma_controller (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  cpu_ce,
	input  logic                  odd_cycle,
	input  logic                  sprite_trigger, // Write to the sprite DMA register
	input  logic                  dmc_request,    // Level from the APU side
	input  logic                  cpu_rnw,
	input  nes_bus_pkg::byte_t    cpu_dout,       // Source page on trigger
	input  nes_bus_pkg::byte_t    ram_data,       // Byte returned on the bus
	input  nes_bus_pkg::cpu_addr_t dmc_addr,
	output nes_bus_pkg::cpu_addr_t dma_addr,
	output logic                  dma_enable,     // DMA drives the bus
	output logic                  dma_read,
	output nes_bus_pkg::byte_t    dma_wdata,
	output logic                  dmc_ack,
	output logic                  pause_cpu
);

	nes_bus_pkg::spr_state_t spr_state;
	nes_bus_pkg::dmc_state_t dmc_state;
	nes_bus_pkg::cpu_addr_t  spr_addr;  // Page in the high byte, step in the low byte
	nes_bus_pkg::byte_t      last_byte; // Byte held between read and OAM write
	logic [8:0]              step_addr; // Carry flags the end of the page

	assign step_addr = {1'b0, spr_addr[7:0]} + 9'd1;

	// State moves only on CPU ticks, later lines take priority
	always_ff @(posedge clk) begin
		if (reset) begin
			spr_state <= nes_bus_pkg::SPR_IDLE;
			dmc_state <= nes_bus_pkg::DMC_IDLE;
		end else if (cpu_ce) begin
			// DMC needs the CPU in a read and an even cycle
			if (dmc_state == nes_bus_pkg::DMC_IDLE && dmc_request && cpu_rnw && !odd_cycle)
				dmc_state <= nes_bus_pkg::DMC_FETCH;
			if (dmc_state == nes_bus_pkg::DMC_FETCH && !odd_cycle)
				dmc_state <= nes_bus_pkg::DMC_IDLE; // Fetch done in this even cycle

			if (sprite_trigger)
				spr_state <= nes_bus_pkg::SPR_WAIT;
			// Start on an odd read cycle so reads land on even cycles
			if (spr_state == nes_bus_pkg::SPR_WAIT && cpu_rnw && odd_cycle)
				spr_state <= nes_bus_pkg::SPR_RUN;
			// DMC steals the even slot, sprite goes back to waiting
			if (spr_state == nes_bus_pkg::SPR_RUN && !odd_cycle &&
					dmc_state == nes_bus_pkg::DMC_FETCH)
				spr_state <= nes_bus_pkg::SPR_WAIT;
			if (spr_state == nes_bus_pkg::SPR_RUN && odd_cycle && step_addr[8])
				spr_state <= nes_bus_pkg::SPR_IDLE; // 256th write done
		end
	end

	// Address and data latches
	always_ff @(posedge clk) begin
		if (cpu_ce) begin
			if (sprite_trigger)
				spr_addr <= {cpu_dout, 8'h00};
			if (spr_state == nes_bus_pkg::SPR_RUN && odd_cycle)
				spr_addr[7:0] <= step_addr[7:0]; // Next byte after each write
			if (spr_state == nes_bus_pkg::SPR_RUN)
				last_byte <= ram_data;
		end
	end

	// Held while a sprite copy is pending or DMC asks
	assign pause_cpu = (spr_state != nes_bus_pkg::SPR_IDLE) || dmc_request;
	assign dmc_ack = (dmc_state == nes_bus_pkg::DMC_FETCH) && !odd_cycle;
	assign dma_enable = dmc_ack || (spr_state == nes_bus_pkg::SPR_RUN);
	assign dma_read = !odd_cycle; // Even reads, odd writes
	assign dma_wdata = last_byte;

	// DMC first, then sprite source, then the OAM data port
	always_comb begin
		if (dmc_ack)
			dma_addr = dmc_addr;
		else if (!odd_cycle)
			dma_addr = spr_addr;
		else
			dma_addr = nes_bus_pkg::OAM_DATA_ADDR;
	end

endmodule

// ==== design/bus_decoder.sv ====
/* Bus master select, address decode, PPU/PRG/joypad strobes,
   open-bus latch and CPU read-data mux */

`timescale 1ns/100ps

module bus_decoder (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   m2,
	input  logic                   cart_pre,
	input  nes_bus_pkg::cpu_addr_t cpu_addr,
	input  nes_bus_pkg::byte_t     cpu_dout,
	input  logic                   cpu_rnw,
	input  nes_bus_pkg::cpu_addr_t dma_addr,
	input  nes_bus_pkg::byte_t     dma_wdata,
	input  logic                   dma_enable,
	input  logic                   dma_read,
	input  nes_bus_pkg::byte_t     ppu_din,        // PPU register read data
	input  nes_bus_pkg::byte_t     memory_din_cpu, // PRG data from memory
	input  logic [3:0]             joypad_data,
	input  logic                   mic,
	output nes_bus_pkg::cpu_addr_t bus_addr,
	output nes_bus_pkg::byte_t     bus_dout,
	output logic                   bus_read,
	output logic                   bus_write,
	output logic                   ppu_read,
	output logic                   ppu_write,
	output logic                   prg_read,
	output logic                   prg_write,
	output logic                   sprite_trigger,
	output logic                   joypad_strobe,
	output logic [1:0]             joypad_clock,
	output nes_bus_pkg::byte_t     cpu_din
);

	nes_bus_pkg::bus_region_t region;
	nes_bus_pkg::byte_t       open_bus; // Last value seen on the data bus

	// DMA takes over the whole bus while enabled
	assign bus_addr  = dma_enable ? dma_addr : cpu_addr;
	assign bus_dout  = dma_enable ? dma_wdata : cpu_dout;
	assign bus_read  = dma_enable ? dma_read : cpu_rnw;
	assign bus_write = dma_enable ? !dma_read : !cpu_rnw;

	// Region decode, joypads inside the APU range checked first
	always_comb begin
		if (bus_addr >= nes_bus_pkg::PPU_BASE && bus_addr < nes_bus_pkg::PPU_END)
			region = nes_bus_pkg::REGION_PPU;
		else if (bus_addr == nes_bus_pkg::JOY1_ADDR)
			region = nes_bus_pkg::REGION_JOY1;
		else if (bus_addr == nes_bus_pkg::JOY2_ADDR)
			region = nes_bus_pkg::REGION_JOY2;
		else if (bus_addr == nes_bus_pkg::APU_STATUS_ADDR)
			region = nes_bus_pkg::REGION_OPEN; // No APU here, status floats
		else if (bus_addr >= nes_bus_pkg::APU_BASE && bus_addr < nes_bus_pkg::APU_END)
			region = nes_bus_pkg::REGION_APU;
		else if (bus_addr >= nes_bus_pkg::APU_END && bus_addr < nes_bus_pkg::OPEN_END)
			region = nes_bus_pkg::REGION_OPEN;
		else
			region = nes_bus_pkg::REGION_PRG;
	end

	// PPU chip select is qualified by M2
	assign ppu_read  = bus_read && m2 && (region == nes_bus_pkg::REGION_PPU);
	assign ppu_write = bus_write && m2 && (region == nes_bus_pkg::REGION_PPU);

	// Cart sees the access early in the CPU cycle
	assign prg_read  = bus_read && cart_pre && (region == nes_bus_pkg::REGION_PRG);
	assign prg_write = bus_write && cart_pre && (region == nes_bus_pkg::REGION_PRG);

	assign sprite_trigger = bus_write && (bus_addr == nes_bus_pkg::SPRITE_DMA_ADDR);

	// Strobe follows bit 0 of the write to 4016
	assign joypad_strobe = bus_write && (region == nes_bus_pkg::REGION_JOY1) && bus_dout[0];
	assign joypad_clock = {bus_read && (region == nes_bus_pkg::REGION_JOY2),
		bus_read && (region == nes_bus_pkg::REGION_JOY1)};

	// Read data mux
	always_comb begin
		if (reset) begin
			cpu_din = 8'h00;
		end else begin
			case (region)
				nes_bus_pkg::REGION_JOY1:
					cpu_din = {open_bus[7:5], 2'b00, mic, 1'b0, joypad_data[0]};
				nes_bus_pkg::REGION_JOY2:
					cpu_din = {open_bus[7:5], joypad_data[3:2], 2'b00, joypad_data[1]};
				nes_bus_pkg::REGION_PPU: cpu_din = ppu_din;
				nes_bus_pkg::REGION_PRG: cpu_din = memory_din_cpu;
				default: cpu_din = open_bus; // Undriven APU and gap addresses
			endcase
		end
	end

	// Bus capacitance keeps the previous byte
	always_ff @(posedge clk) begin
		open_bus <= cpu_din;
	end

endmodule

// ==== design/memory_multiplex.sv ====
/* Shares one memory between PRG and CHR, CHR first,
   with PRG requests held until CHR goes idle */

`timescale 1ns/100ps

module memory_multiplex #(
	parameter int MEM_ADDR_WIDTH = nes_bus_pkg::MEM_ADDR_WIDTH_DEFAULT
) (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      ppu_ce,
	input  nes_bus_pkg::cpu_addr_t    prg_addr,
	input  logic                      prg_read,
	input  logic                      prg_write,
	input  nes_bus_pkg::byte_t        prg_din,
	input  logic [MEM_ADDR_WIDTH-1:0] chr_addr,
	input  logic                      chr_read,
	input  logic                      chr_write,
	input  nes_bus_pkg::byte_t        chr_din,
	output logic [MEM_ADDR_WIDTH-1:0] memory_addr,
	output logic                      memory_read_cpu, // Load the CPU latch
	output logic                      memory_read_ppu, // Load the PPU latch
	output logic                      memory_write,
	output nes_bus_pkg::byte_t        memory_dout
);

	logic                      chr_busy;        // Any CHR access this clock
	logic                      saved_prg_read;
	logic                      saved_prg_write;
	logic [MEM_ADDR_WIDTH-1:0] prg_lin;         // No mapper, CPU address as is

	assign chr_busy = chr_read || chr_write;
	assign prg_lin = MEM_ADDR_WIDTH'(prg_addr);

	assign memory_addr = chr_busy ? chr_addr : prg_lin;
	assign memory_read_ppu = chr_read;
	assign memory_read_cpu = !chr_busy && (prg_read || saved_prg_read);
	assign memory_write = chr_busy ? chr_write : saved_prg_write; // PRG write lands a tick late
	assign memory_dout = chr_write ? chr_din : prg_din;

	// Pending flags sampled per PPU tick
	always_ff @(posedge clk) begin
		if (reset) begin
			saved_prg_read  <= 1'b0;
			saved_prg_write <= 1'b0;
		end else if (ppu_ce) begin
			if (chr_busy) begin
				// Keep PRG requests until memory frees up
				saved_prg_read  <= prg_read || saved_prg_read;
				saved_prg_write <= prg_write || saved_prg_write;
			end else begin
				saved_prg_read  <= 1'b0; // Read served this tick
				saved_prg_write <= prg_write;
			end
		end
	end

endmodule

// ==== design/nes_bus.sv ====
/* NES CPU bus core top, clock divider, DMA, decoder
   and memory multiplexer */

`timescale 1ns/100ps

module nes_bus #(
	parameter int CPU_DIV        = nes_bus_pkg::CPU_DIV_DEFAULT,
	parameter int PPU_DIV        = nes_bus_pkg::PPU_DIV_DEFAULT,
	parameter int MEM_ADDR_WIDTH = nes_bus_pkg::MEM_ADDR_WIDTH_DEFAULT
) (
	input  logic                      clk,
	input  logic                      reset,
	input  nes_bus_pkg::cpu_addr_t    cpu_addr,
	input  nes_bus_pkg::byte_t        cpu_dout,
	input  logic                      cpu_rnw,
	input  logic                      dmc_request,
	input  nes_bus_pkg::cpu_addr_t    dmc_addr,
	input  nes_bus_pkg::byte_t        ppu_din,
	input  logic [MEM_ADDR_WIDTH-1:0] chr_addr,
	input  logic                      chr_read,
	input  logic                      chr_write,
	input  nes_bus_pkg::byte_t        chr_din,
	input  nes_bus_pkg::byte_t        memory_din_cpu,
	input  logic [3:0]                joypad_data,
	input  logic                      mic,
	output logic                      cpu_ce,
	output logic                      ppu_ce,
	output logic                      pause_cpu,
	output nes_bus_pkg::byte_t        cpu_din,
	output logic                      dmc_ack,
	output nes_bus_pkg::cpu_addr_t    bus_addr,
	output nes_bus_pkg::byte_t        bus_dout,
	output logic                      bus_read,
	output logic                      bus_write,
	output logic                      ppu_read,
	output logic                      ppu_write,
	output logic                      joypad_strobe,
	output logic [1:0]                joypad_clock,
	output logic [MEM_ADDR_WIDTH-1:0] memory_addr,
	output logic                      memory_read_cpu,
	output logic                      memory_read_ppu,
	output logic                      memory_write,
	output nes_bus_pkg::byte_t        memory_dout
);

	logic                   m2;
	logic                   cart_pre;
	logic                   odd_cycle;
	nes_bus_pkg::cpu_addr_t dma_addr;
	logic                   dma_enable;
	logic                   dma_read;
	nes_bus_pkg::byte_t     dma_wdata;
	logic                   sprite_trigger;
	logic                   prg_read;
	logic                   prg_write;

	clock_divider #(.CPU_DIV(CPU_DIV), .PPU_DIV(PPU_DIV)) u_clock_divider (
		.clk(clk), .reset(reset),
		.cpu_ce(cpu_ce), .ppu_ce(ppu_ce),
		.m2(m2), .cart_pre(cart_pre), .odd_cycle(odd_cycle)
	);

	// DMA reads back through the same data mux as the CPU
	dma_controller u_dma_controller (
		.clk(clk), .reset(reset), .cpu_ce(cpu_ce), .odd_cycle(odd_cycle),
		.sprite_trigger(sprite_trigger), .dmc_request(dmc_request), .cpu_rnw(cpu_rnw),
		.cpu_dout(cpu_dout), .ram_data(cpu_din), .dmc_addr(dmc_addr),
		.dma_addr(dma_addr), .dma_enable(dma_enable), .dma_read(dma_read),
		.dma_wdata(dma_wdata), .dmc_ack(dmc_ack), .pause_cpu(pause_cpu)
	);

	bus_decoder u_bus_decoder (
		.clk(clk), .reset(reset), .m2(m2), .cart_pre(cart_pre),
		.cpu_addr(cpu_addr), .cpu_dout(cpu_dout), .cpu_rnw(cpu_rnw),
		.dma_addr(dma_addr), .dma_wdata(dma_wdata),
		.dma_enable(dma_enable), .dma_read(dma_read),
		.ppu_din(ppu_din), .memory_din_cpu(memory_din_cpu),
		.joypad_data(joypad_data), .mic(mic),
		.bus_addr(bus_addr), .bus_dout(bus_dout),
		.bus_read(bus_read), .bus_write(bus_write),
		.ppu_read(ppu_read), .ppu_write(ppu_write),
		.prg_read(prg_read), .prg_write(prg_write),
		.sprite_trigger(sprite_trigger), .joypad_strobe(joypad_strobe),
		.joypad_clock(joypad_clock), .cpu_din(cpu_din)
	);

	// PRG side sees the muxed bus, cart mapping is identity
	memory_multiplex #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) u_memory_multiplex (
		.clk(clk), .reset(reset), .ppu_ce(ppu_ce),
		.prg_addr(bus_addr), .prg_read(prg_read), .prg_write(prg_write),
		.prg_din(bus_dout),
		.chr_addr(chr_addr), .chr_read(chr_read), .chr_write(chr_write),
		.chr_din(chr_din),
		.memory_addr(memory_addr), .memory_read_cpu(memory_read_cpu),
		.memory_read_ppu(memory_read_ppu), .memory_write(memory_write),
		.memory_dout(memory_dout)
	);

endmodule

// ==== tests/tb_nes_bus.sv ====
/* Testbench for the NES CPU bus core with memory and joypad models,
   reference read-data function, checks and a cycle timeout */

`timescale 1ns/100ps

module tb_nes_bus;

	localparam int MEM_W = nes_bus_pkg::MEM_ADDR_WIDTH_DEFAULT;
	localparam int CPU_DIV = nes_bus_pkg::CPU_DIV_DEFAULT;
	localparam int PPU_DIV = nes_bus_pkg::PPU_DIV_DEFAULT;
	localparam int CLOCK_LIMIT = 3000 * CPU_DIV; // Two sprite copies plus short tests
	localparam logic [31:0] SEED = 32'd65668;

	logic clk = 1'b0;
	logic reset = 1'b1;
	nes_bus_pkg::cpu_addr_t cpu_addr, dmc_addr, bus_addr;
	nes_bus_pkg::byte_t cpu_dout, ppu_din, chr_din, memory_din_cpu, cpu_din, bus_dout, memory_dout;
	logic cpu_rnw, dmc_request, chr_read, chr_write, mic;
	logic [MEM_W-1:0] chr_addr, memory_addr;
	logic [3:0] joypad_data;
	logic cpu_ce, ppu_ce, pause_cpu, dmc_ack, bus_read, bus_write, ppu_read, ppu_write;
	logic joypad_strobe, memory_read_cpu, memory_read_ppu, memory_write;
	logic [1:0] joypad_clock;

	nes_bus_pkg::byte_t open_model = 8'h00; // Expected open-bus latch
	nes_bus_pkg::byte_t cur_ref = 8'h00;
	nes_bus_pkg::byte_t spr_page, spr_byte, last_din;
	int clk_count = 0;
	int run_clocks = 0;
	int spr_idx, pair_count;
	int ack_count = 0;
	int cpu_phase;      // Master clock count inside the CPU cycle, 1..CPU_DIV
	logic m2_ref, ppu_hit;
	logic saw_mem_read, saw_mem_write, saw_strobe;
	logic [1:0] saw_clock;

	nes_bus u_nes_bus (
		.clk(clk), .reset(reset), .cpu_addr(cpu_addr), .cpu_dout(cpu_dout), .cpu_rnw(cpu_rnw),
		.dmc_request(dmc_request), .dmc_addr(dmc_addr), .ppu_din(ppu_din),
		.chr_addr(chr_addr), .chr_read(chr_read), .chr_write(chr_write), .chr_din(chr_din),
		.memory_din_cpu(memory_din_cpu), .joypad_data(joypad_data), .mic(mic),
		.cpu_ce(cpu_ce), .ppu_ce(ppu_ce), .pause_cpu(pause_cpu), .cpu_din(cpu_din),
		.dmc_ack(dmc_ack), .bus_addr(bus_addr), .bus_dout(bus_dout), .bus_read(bus_read),
		.bus_write(bus_write), .ppu_read(ppu_read), .ppu_write(ppu_write),
		.joypad_strobe(joypad_strobe), .joypad_clock(joypad_clock),
		.memory_addr(memory_addr), .memory_read_cpu(memory_read_cpu),
		.memory_read_ppu(memory_read_ppu), .memory_write(memory_write),
		.memory_dout(memory_dout)
	);

	always #20 clk = ~clk; // 40 ns period

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Memory contents, every address bit feeds the hash
	function automatic nes_bus_pkg::byte_t mem_byte(input logic [MEM_W-1:0] a);
		logic [31:0] x;
		x = (32'(a) ^ SEED) + 32'h9e3779b9;
		x = xorshift32(xorshift32(x));
		return x[7:0];
	endfunction

	assign memory_din_cpu = mem_byte(memory_addr); // Zero wait memory

	// Expected cpu_din from the read-data table
	function automatic nes_bus_pkg::byte_t ref_cpu_din(input nes_bus_pkg::cpu_addr_t a,
			input nes_bus_pkg::byte_t ob, input logic chr_busy);
		if (a >= nes_bus_pkg::PPU_BASE && a < nes_bus_pkg::PPU_END)
			return ppu_din;
		if (a == nes_bus_pkg::JOY1_ADDR)
			return {ob[7:5], 2'b00, mic, 1'b0, joypad_data[0]};
		if (a == nes_bus_pkg::JOY2_ADDR)
			return {ob[7:5], joypad_data[3:2], 2'b00, joypad_data[1]};
		if (a >= nes_bus_pkg::APU_BASE && a < nes_bus_pkg::OPEN_END)
			return ob; // APU, status and unmapped gap
		return chr_busy ? mem_byte(chr_addr) : mem_byte(MEM_W'(a)); // CHR owns memory
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Fail %s expected %0h actual %0h", name, expected, actual);
			$display("*** TEST FAILED ***");
			$fatal(1, "Output value did not match the expected value");
		end
	endtask

	// Per clock comparison, sampled mid period
	always @(negedge clk) begin
		if (reset) begin
			check_value("cpu_ce in reset", 32'(0), 32'(cpu_ce));
			check_value("ppu_ce in reset", 32'(0), 32'(ppu_ce));
			cur_ref = 8'h00;
		end else begin
			clk_count = clk_count + 1;
			check_value("cpu_ce period", 32'(clk_count % CPU_DIV == 0), 32'(cpu_ce));
			check_value("ppu_ce period", 32'(clk_count % PPU_DIV == 0), 32'(ppu_ce));
			cur_ref = ref_cpu_din(bus_addr, open_model, chr_read || chr_write);
			check_value("cpu_din", 32'(cur_ref), 32'(cpu_din));
			// M2 high from half the divisor minus one up to the CPU tick
			cpu_phase = (clk_count - 1) % CPU_DIV + 1;
			m2_ref = cpu_phase >= CPU_DIV / 2 - 1 && cpu_phase < CPU_DIV;
			ppu_hit = bus_addr >= nes_bus_pkg::PPU_BASE && bus_addr < nes_bus_pkg::PPU_END;
			check_value("ppu_read", 32'(bus_read && m2_ref && ppu_hit), 32'(ppu_read));
			check_value("ppu_write", 32'(bus_write && m2_ref && ppu_hit), 32'(ppu_write));
			check_value("memory_read_ppu", 32'(chr_read), 32'(memory_read_ppu));
			if (chr_read || chr_write) begin
				check_value("chr memory_addr", 32'(chr_addr), 32'(memory_addr));
				check_value("chr memory_write", 32'(chr_write), 32'(memory_write));
				check_value("prg held off", 32'(0), 32'(memory_read_cpu));
			end
			if (dmc_request)
				check_value("pause with dmc", 32'(1), 32'(pause_cpu));
			if (!pause_cpu) begin
				check_value("cpu bus_addr", 32'(cpu_addr), 32'(bus_addr));
				check_value("cpu bus_read", 32'(cpu_rnw), 32'(bus_read));
				check_value("cpu bus_write", 32'(!cpu_rnw), 32'(bus_write));
			end
			if (dmc_ack) begin
				check_value("dmc bus_addr", 32'(dmc_addr), 32'(bus_addr));
				if (cpu_ce)
					ack_count = ack_count + 1;
			end else if (cpu_ce && u_nes_bus.dma_enable) begin
				if (bus_read) begin
					check_value("sprite read addr", 32'({spr_page, 8'(spr_idx)}), 32'(bus_addr));
					check_value("sprite read strobe", 32'(0), 32'(bus_write));
					spr_byte = mem_byte(MEM_W'({spr_page, 8'(spr_idx)}));
				end else begin
					check_value("sprite oam addr", 32'(nes_bus_pkg::OAM_DATA_ADDR),
						32'(bus_addr));
					check_value("sprite oam strobe", 32'(1), 32'(bus_write));
					check_value("sprite oam data", 32'(spr_byte), 32'(bus_dout));
					spr_idx = spr_idx + 1;
					pair_count = pair_count + 1;
				end
			end
		end
	end

	always @(posedge clk) begin
		open_model <= cur_ref; // Latch follows last clock's data
		run_clocks <= run_clocks + 1;
		if (run_clocks > CLOCK_LIMIT) begin
			$display("*** TEST FAILED ***");
			$fatal(1, "Timeout, the tests did not finish within the cycle limit");
		end
	end

	// Align to the start of a CPU cycle
	task automatic cpu_sync();
		@(negedge clk);
		while (!cpu_ce)
			@(negedge clk);
		@(posedge clk);
		#2;
	endtask

	// One CPU bus cycle, repeated while paused
	task automatic cpu_access(input nes_bus_pkg::cpu_addr_t a, input nes_bus_pkg::byte_t d,
			input logic rnw);
		logic held;
		cpu_addr = a;
		cpu_dout = d;
		cpu_rnw = rnw;
		saw_mem_read = 1'b0;
		saw_mem_write = 1'b0;
		saw_strobe = 1'b0;
		saw_clock = 2'b00;
		held = 1'b1;
		while (held) begin
			@(negedge clk);
			if (memory_read_cpu && memory_addr == MEM_W'(a))
				saw_mem_read = 1'b1;
			if (memory_write) begin
				saw_mem_write = 1'b1;
				check_value("prg write addr", 32'(MEM_W'(a)), 32'(memory_addr));
				check_value("prg write data", 32'(d), 32'(memory_dout));
			end
			saw_strobe = saw_strobe | joypad_strobe;
			saw_clock = saw_clock | joypad_clock;
			if (cpu_ce) begin
				held = pause_cpu; // Paused cycle repeats
				last_din = cpu_din;
				@(posedge clk);
				#2;
			end
		end
	endtask

	task automatic drop_dmc_after_ack(input int start_count);
		while (ack_count == start_count)
			@(negedge clk);
		@(posedge clk);
		#2;
		dmc_request = 1'b0;
	endtask

	task automatic dmc_during_sprite();
		while (pair_count < 40)
			@(negedge clk);
		@(posedge clk);
		#2;
		dmc_request = 1'b1;
		drop_dmc_after_ack(ack_count);
	endtask

	task automatic run_sprite_dma(input nes_bus_pkg::byte_t page, input logic with_dmc);
		int acks;
		spr_page = page;
		spr_idx = 0;
		pair_count = 0;
		acks = ack_count;
		cpu_access(nes_bus_pkg::SPRITE_DMA_ADDR, page, 1'b0);
		check_value("pause after trigger", 32'(1), 32'(pause_cpu));
		if (with_dmc) begin
			fork
				cpu_access(16'h8000, 8'h00, 1'b1);
				dmc_during_sprite();
			join
			check_value("dmc ack in sprite", 32'(acks + 1), 32'(ack_count));
		end else begin
			cpu_access(16'h8000, 8'h00, 1'b1);
		end
		check_value("sprite pairs", 32'(256), 32'(pair_count));
		check_value("pause released", 32'(0), 32'(pause_cpu));
	endtask

	initial begin
		int acks;
		logic found;
		cpu_addr = 16'h8000;
		cpu_dout = 8'h00;
		cpu_rnw = 1'b1;
		dmc_request = 1'b0;
		dmc_addr = 16'hc123;
		ppu_din = 8'he5;
		chr_addr = '0;
		chr_read = 1'b0;
		chr_write = 1'b0;
		chr_din = 8'h00;
		joypad_data = 4'b1010;
		mic = 1'b1;
		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;
		cpu_sync();

		// Joypads and open bus
		cpu_access(nes_bus_pkg::JOY1_ADDR, 8'h01, 1'b0);
		check_value("strobe set", 32'(1), 32'(saw_strobe));
		cpu_access(nes_bus_pkg::JOY1_ADDR, 8'h00, 1'b0);
		check_value("strobe clear", 32'(0), 32'(saw_strobe));
		cpu_access(16'h2002, 8'h00, 1'b1); // Loads E5 onto the bus
		cpu_access(16'h4020, 8'h00, 1'b1);
		check_value("open range read", 32'(8'he5), 32'(last_din));
		cpu_access(nes_bus_pkg::JOY1_ADDR, 8'h00, 1'b1);
		check_value("joy1 clock", 32'(2'b01), 32'(saw_clock));
		check_value("joy1 data", 32'(ref_cpu_din(nes_bus_pkg::JOY1_ADDR, 8'he5, 1'b0)),
			32'(last_din));
		cpu_access(nes_bus_pkg::JOY2_ADDR, 8'h00, 1'b1);
		check_value("joy2 clock", 32'(2'b10), 32'(saw_clock));
		check_value("joy2 data", 32'(ref_cpu_din(nes_bus_pkg::JOY2_ADDR, 8'he5, 1'b0)),
			32'(last_din));

		// PRG read, CHR idle
		cpu_access(16'h8123, 8'h00, 1'b1);
		check_value("prg memory read", 32'(1), 32'(saw_mem_read));
		check_value("prg data", 32'(mem_byte(MEM_W'(16'h8123))), 32'(last_din));
		check_value("prg no write", 32'(0), 32'(saw_mem_write));

		// PRG write reaches memory with the CPU byte
		cpu_access(16'h8765, 8'h3c, 1'b0);
		check_value("prg write", 32'(1), 32'(saw_mem_write));

		run_sprite_dma(8'h80, 1'b0);

		// DMC alone, CPU held on a read
		acks = ack_count;
		dmc_request = 1'b1;
		fork
			cpu_access(16'h8000, 8'h00, 1'b1);
			drop_dmc_after_ack(acks);
		join
		check_value("dmc ack", 32'(acks + 1), 32'(ack_count));

		run_sprite_dma(8'h91, 1'b1);

		// CHR holds memory, PRG read gets saved
		chr_addr = MEM_W'(22'h2abcd);
		chr_read = 1'b1;
		cpu_access(16'h8456, 8'h00, 1'b1);
		// Past the cart window, only the saved request can reach memory
		repeat (PPU_DIV) @(posedge clk);
		#2;
		chr_read = 1'b0;
		found = 1'b0;
		repeat (2 * PPU_DIV) begin
			@(negedge clk);
			if (memory_read_cpu && memory_addr == MEM_W'(16'h8456))
				found = 1'b1;
		end
		check_value("saved prg read", 32'(1), 32'(found));

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// ==== flist.f ====
design/nes_bus_pkg.sv
design/clock_divider.sv
design/dma_controller.sv
design/bus_decoder.sv
design/memory_multiplex.sv
design/nes_bus.sv
tests/tb_nes_bus.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the NES bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f flist.f --top-module tb_nes_bus -o tb_nes_bus; then
	echo "Verilator build failed"
	exit 1
fi

if ! ./obj_dir/tb_nes_bus; then
	echo "Simulation reported failure"
	exit 1
fi

echo "Simulation finished"
exit 0
